// ==== Makefile ====
# Verilator flow for the game engine testbench

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert --top-module game_top_tb -f game_top.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module game_top_tb \
		-Mdir obj_dir -f game_top.f
	@out="$$(./obj_dir/Vgame_top_tb 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

// ==== game_top.f ====
source/game_pkg.sv
source/game_regs.sv
source/game_timebase.sv
source/game_sprite.sv
source/game_collision.sv
source/game_master_fsm.sv
source/game_top.sv
test/game_top_assertions.sv
test/game_top_tb.sv

// ==== source/game_collision.sv ====
`default_nettype none
`timescale 1ns/1ps

module game_collision
(
    input  logic             clk,
    input  logic             reset,
    input  game_pkg::coord_t ax,
    input  game_pkg::coord_t ay,
    input  game_pkg::coord_t bx,
    input  game_pkg::coord_t by,
    output logic            collision
);

    import game_pkg::*;

    logic overlap_x;
    logic overlap_y;

    // sums are evaluated at integer width, so no wrap near 1023
    assign overlap_x = (ax < bx + sprite_size) & (bx < ax + sprite_size);
    assign overlap_y = (ay < by + sprite_size) & (by < ay + sprite_size);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            collision <= 1'b0;
        else
            collision <= overlap_x & overlap_y;
    end

endmodule

`default_nettype wire

// ==== source/game_master_fsm.sv ====
`default_nettype none
`timescale 1ns/1ps

module game_master_fsm
(
    input  logic clk,
    input  logic reset,
    input  logic run,
    input  logic key,
    output logic target_write_xy,
    output logic torpedo_write_xy,
    output logic target_write_dxy,
    output logic torpedo_write_dxy,
    output logic target_enable_update,
    output logic torpedo_enable_update,
    input  logic target_within_screen,
    input  logic torpedo_within_screen,
    input  logic collision,
    input  logic end_timer_running,
    output logic end_timer_start,
    output logic round_start,
    output logic game_won,
    output logic game_over
);

    import game_pkg::*;

    game_state_t state;
    game_state_t next_state;

    logic next_target_write_xy;
    logic next_torpedo_write_xy;
    logic next_target_write_dxy;
    logic next_torpedo_write_dxy;
    logic next_target_enable_update;
    logic next_torpedo_enable_update;
    logic next_end_timer_start;
    logic next_round_start;
    logic next_game_won;
    logic next_game_over;

    always_comb
    begin
        next_state                 = state;
        next_target_write_xy       = 1'b0;
        next_torpedo_write_xy      = 1'b0;
        next_target_write_dxy      = 1'b0;
        next_torpedo_write_dxy     = 1'b0;
        next_target_enable_update  = 1'b0;
        next_torpedo_enable_update = 1'b0;
        next_end_timer_start       = 1'b0;
        next_round_start           = 1'b0;
        next_game_won              = game_won;

        case (state)
            state_start:
            begin
                if (run)
                begin
                    next_target_write_xy  = 1'b1;
                    next_torpedo_write_xy = 1'b1;
                    next_target_write_dxy = 1'b1;
                    next_round_start      = 1'b1;
                    next_game_won         = 1'b0;
                    next_state            = state_aim;
                end
            end

            state_aim:
            begin
                next_target_enable_update = 1'b1;

                // wait while the start position load is still in flight
                if (!target_write_xy)
                begin
                    if (key)
                        next_state = state_shoot;
                    else if (!target_within_screen)
                    begin
                        next_end_timer_start = 1'b1;
                        next_state           = state_end;
                    end
                end
            end

            state_shoot:
            begin
                next_torpedo_write_dxy     = 1'b1;
                next_target_enable_update  = 1'b1;
                next_torpedo_enable_update = 1'b1;

                if (collision)
                    next_game_won = 1'b1;

                if (collision || !target_within_screen || !torpedo_within_screen)
                begin
                    next_end_timer_start = 1'b1;
                    next_state           = state_end;
                end
            end

            default:
            begin
                if (collision)
                    next_game_won = 1'b1;  // late hit still counts

                if (!end_timer_running)
                    next_state = state_start;
            end
        endcase

        next_game_over = (next_state == state_end);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state                 <= state_start;
            target_write_xy       <= 1'b0;
            torpedo_write_xy      <= 1'b0;
            target_write_dxy      <= 1'b0;
            torpedo_write_dxy     <= 1'b0;
            target_enable_update  <= 1'b0;
            torpedo_enable_update <= 1'b0;
            end_timer_start       <= 1'b0;
            round_start           <= 1'b0;
            game_won              <= 1'b0;
            game_over             <= 1'b0;
        end
        else
        begin
            state                 <= next_state;
            target_write_xy       <= next_target_write_xy;
            torpedo_write_xy      <= next_torpedo_write_xy;
            target_write_dxy      <= next_target_write_dxy;
            torpedo_write_dxy     <= next_torpedo_write_dxy;
            target_enable_update  <= next_target_enable_update;
            torpedo_enable_update <= next_torpedo_enable_update;
            end_timer_start       <= next_end_timer_start;
            round_start           <= next_round_start;
            game_won              <= next_game_won;
            game_over             <= next_game_over;
        end
    end

endmodule

`default_nettype wire

// ==== source/game_pkg.sv ====
`default_nettype none

package game_pkg;

    typedef logic [9:0]  coord_t;    // screen coordinate
    typedef logic [3:0]  delta_t;    // signed step per tick
    typedef logic [31:0] wb_data_t;
    typedef logic [2:0]  wb_addr_t;  // word address

    localparam int screen_width  = 640;
    localparam int screen_height = 480;
    localparam int sprite_size   = 8;  // square box, top-left anchored

    localparam wb_addr_t reg_control       = 3'd0;
    localparam wb_addr_t reg_target_start  = 3'd1;
    localparam wb_addr_t reg_target_delta  = 3'd2;
    localparam wb_addr_t reg_torpedo_start = 3'd3;
    localparam wb_addr_t reg_torpedo_delta = 3'd4;
    localparam wb_addr_t reg_step_period   = 3'd5;
    localparam wb_addr_t reg_end_delay     = 3'd6;
    localparam wb_addr_t reg_status        = 3'd7;  // read only

    typedef enum logic [1:0]
    {
        state_start = 2'd0,
        state_aim   = 2'd1,
        state_shoot = 2'd2,
        state_end   = 2'd3
    } game_state_t;

endpackage

`default_nettype wire

// ==== source/game_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module game_regs
(
    input  logic               clk,
    input  logic               reset,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  game_pkg::wb_addr_t wb_adr,
    input  game_pkg::wb_data_t wb_dat_w,
    output game_pkg::wb_data_t wb_dat_r,
    output logic               wb_ack,
    output logic               run,
    output game_pkg::coord_t   target_x0,
    output game_pkg::coord_t   target_y0,
    output game_pkg::delta_t   target_dx,
    output game_pkg::delta_t   target_dy,
    output game_pkg::coord_t   torpedo_x0,
    output game_pkg::coord_t   torpedo_y0,
    output game_pkg::delta_t   torpedo_dx,
    output game_pkg::delta_t   torpedo_dy,
    output logic [15:0]        step_period,
    output logic [7:0]         end_delay,
    input  logic               game_won,
    input  logic               game_over,
    input  logic               round_start
);

    import game_pkg::*;

    logic     transfer;
    logic [7:0] rounds_played;
    wb_data_t read_word;

    // ack follows one clock later, never back to back
    assign transfer = wb_cyc & wb_stb & ~wb_ack;

    always_comb
    begin
        case (wb_adr)
            reg_control:       read_word = {31'd0, run};
            reg_target_start:  read_word = {6'd0, target_y0, 6'd0, target_x0};
            reg_target_delta:  read_word = {12'd0, target_dy, 12'd0, target_dx};
            reg_torpedo_start: read_word = {6'd0, torpedo_y0, 6'd0, torpedo_x0};
            reg_torpedo_delta: read_word = {12'd0, torpedo_dy, 12'd0, torpedo_dx};
            reg_step_period:   read_word = {16'd0, step_period};
            reg_end_delay:     read_word = {24'd0, end_delay};
            default:           read_word = {16'd0, rounds_played, 6'd0, game_over, game_won};
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wb_ack        <= 1'b0;
            run           <= 1'b0;
            target_x0     <= '0;
            target_y0     <= '0;
            target_dx     <= '0;
            target_dy     <= '0;
            torpedo_x0    <= '0;
            torpedo_y0    <= '0;
            torpedo_dx    <= '0;
            torpedo_dy    <= '0;
            step_period   <= 16'd1;
            end_delay     <= 8'd1;
            rounds_played <= 8'd0;
        end
        else
        begin
            wb_ack <= transfer;

            if (transfer && wb_we)
            begin
                case (wb_adr)
                    reg_control:       run <= wb_dat_w[0];
                    reg_target_start:  {target_y0, target_x0} <= {wb_dat_w[25:16], wb_dat_w[9:0]};
                    reg_target_delta:  {target_dy, target_dx} <= {wb_dat_w[19:16], wb_dat_w[3:0]};
                    reg_torpedo_start: {torpedo_y0, torpedo_x0} <= {wb_dat_w[25:16], wb_dat_w[9:0]};
                    reg_torpedo_delta: {torpedo_dy, torpedo_dx} <= {wb_dat_w[19:16], wb_dat_w[3:0]};
                    reg_step_period:   step_period <= wb_dat_w[15:0];
                    reg_end_delay:     end_delay   <= wb_dat_w[7:0];
                    default:           ;  // status is read only
                endcase
            end

            if (round_start)
                rounds_played <= rounds_played + 8'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (transfer)
            wb_dat_r <= read_word;  // held while ack is high
    end

endmodule

`default_nettype wire

// ==== source/game_sprite.sv ====
`default_nettype none
`timescale 1ns/1ps

module game_sprite
(
    input  logic             clk,
    input  logic             reset,
    input  game_pkg::coord_t x0,
    input  game_pkg::coord_t y0,
    input  game_pkg::delta_t dx,
    input  game_pkg::delta_t dy,
    input  logic             write_xy,
    input  logic             write_dxy,
    input  logic             enable_update,
    input  logic             step_tick,
    output game_pkg::coord_t x,
    output game_pkg::coord_t y,
    output logic             within_screen
);

    import game_pkg::*;

    delta_t vx;
    delta_t vy;
    coord_t step_x;
    coord_t step_y;

    // sign extend the 4-bit velocity to coordinate width
    assign step_x = {{6{vx[3]}}, vx};
    assign step_y = {{6{vy[3]}}, vy};

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            vx <= '0;
            vy <= '0;
        end
        else if (write_dxy)
        begin
            vx <= dx;
            vy <= dy;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            x <= '0;
            y <= '0;
        end
        else if (write_xy)
        begin
            x <= x0;  // start position wins over motion
            y <= y0;
        end
        else if (enable_update && step_tick)
        begin
            x <= x + step_x;  // wraps modulo 1024
            y <= y + step_y;
        end
    end

    // wrapping below zero gives a large value, so both edges read as off screen
    assign within_screen = (x < screen_width  - sprite_size)
                         & (y < screen_height - sprite_size);

endmodule

`default_nettype wire

// ==== source/game_timebase.sv ====
`default_nettype none
`timescale 1ns/1ps

module game_timebase
(
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] step_period,
    input  logic [7:0]  end_delay,
    input  logic        end_timer_start,
    output logic        step_tick,
    output logic        end_timer_running
);

    logic [15:0] step_count;
    logic [7:0]  end_count;
    logic        last_clock;

    // a period of zero behaves like a period of one
    assign last_clock = (step_count + 16'd1 >= step_period);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            step_count <= 16'd0;
            step_tick  <= 1'b0;
        end
        else if (last_clock)
        begin
            step_count <= 16'd0;
            step_tick  <= 1'b1;
        end
        else
        begin
            step_count <= step_count + 16'd1;
            step_tick  <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            end_count <= 8'd0;
        else if (end_timer_start)
            end_count <= end_delay;
        else if (step_tick && end_count != 8'd0)
            end_count <= end_count - 8'd1;  // one step per tick
    end

    // the start pulse itself counts, so the FSM never sees a gap before the load
    assign end_timer_running = end_timer_start | (end_count != 8'd0);

endmodule

`default_nettype wire

// ==== source/game_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module game_top
(
    input  logic               clk,
    input  logic               reset,
    input  logic               key,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  game_pkg::wb_addr_t wb_adr,
    input  game_pkg::wb_data_t wb_dat_w,
    output game_pkg::wb_data_t wb_dat_r,
    output logic               wb_ack
);

    import game_pkg::*;

    logic        run;
    coord_t      target_x0, target_y0, torpedo_x0, torpedo_y0;
    delta_t      target_dx, target_dy, torpedo_dx, torpedo_dy;
    logic [15:0] step_period;
    logic [7:0]  end_delay;
    logic        step_tick, end_timer_start, end_timer_running;
    coord_t      target_x, target_y, torpedo_x, torpedo_y;
    logic        target_within_screen, torpedo_within_screen, collision;
    logic        target_write_xy, torpedo_write_xy;
    logic        target_write_dxy, torpedo_write_dxy;
    logic        target_enable_update, torpedo_enable_update;
    logic        round_start, game_won, game_over;

    game_regs game_regs_inst (.*);

    game_timebase game_timebase_inst (.*);

    game_sprite target_sprite
    (
        .clk, .reset, .step_tick,
        .x0 (target_x0), .y0 (target_y0), .dx (target_dx), .dy (target_dy),
        .write_xy (target_write_xy), .write_dxy (target_write_dxy),
        .enable_update (target_enable_update),
        .x (target_x), .y (target_y), .within_screen (target_within_screen)
    );

    game_sprite torpedo_sprite
    (
        .clk, .reset, .step_tick,
        .x0 (torpedo_x0), .y0 (torpedo_y0), .dx (torpedo_dx), .dy (torpedo_dy),
        .write_xy (torpedo_write_xy), .write_dxy (torpedo_write_dxy),
        .enable_update (torpedo_enable_update),
        .x (torpedo_x), .y (torpedo_y), .within_screen (torpedo_within_screen)
    );

    game_collision game_collision_inst
    (
        .clk, .reset, .collision,
        .ax (target_x), .ay (target_y), .bx (torpedo_x), .by (torpedo_y)
    );

    game_master_fsm game_master_fsm_inst (.*);

endmodule

`default_nettype wire

// ==== test/game_top_assertions.sv ====
`default_nettype none
`timescale 1ns/1ps

module game_top_assertions
(
    input logic clk,
    input logic reset,
    input logic run,
    input logic key,
    input logic wb_ack,
    input logic target_write_xy,
    input logic torpedo_write_xy,
    input logic target_write_dxy,
    input logic torpedo_write_dxy,
    input logic target_enable_update,
    input logic torpedo_enable_update,
    input logic end_timer_start,
    input logic round_start,
    input logic game_won,
    input logic game_over
);

    logic any_output;

    assign any_output = wb_ack | target_write_xy | torpedo_write_xy | target_write_dxy
                      | torpedo_write_dxy | target_enable_update | torpedo_enable_update
                      | end_timer_start | round_start | game_won | game_over;

    ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
        else $error("wb_ack high in two consecutive cycles");

    // start loads come one clock after run is seen, with the round start pulse
    start_strobes: assert property (@(posedge clk) disable iff (reset)
        (target_write_xy | torpedo_write_xy | target_write_dxy) |-> round_start && $past(run))
        else $error("start position or target velocity loaded outside a round start");

    // the first torpedo velocity load follows key by two clocks, then repeats in shoot
    shoot_strobe: assert property (@(posedge clk) disable iff (reset)
        torpedo_write_dxy |-> torpedo_enable_update
                              && ($past(key, 2) || $past(torpedo_write_dxy)))
        else $error("torpedo velocity loaded outside the shoot state");

    // a new round passes through the start state after the end state
    start_not_over: assert property (@(posedge clk) disable iff (reset)
        round_start |-> !game_over && !$past(game_over))
        else $error("round start while or right after game over is high");

    reset_quiet: assert property (@(posedge clk) reset |=> !any_output)
        else $error("output high right after reset");

endmodule

bind game_top game_top_assertions game_top_assertions_inst (.*);

`default_nettype wire

// ==== test/game_top_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module game_top_tb;

    import game_pkg::*;

    localparam int step_clocks = 4;
    localparam int end_steps   = 8;
    localparam int idle_cycles = 2000;
    // worst flight crosses 1024 rows at 4 per step, then the hold, plus bus traffic
    localparam int round_cycles   = (1024 / 4 + end_steps) * step_clocks + 200;
    localparam int timeout_cycles = 8 * round_cycles + idle_cycles + 1000;

    localparam int torpedo_x = 300;
    localparam int torpedo_y = 460;
    localparam int target_y  = 40;

    logic     clk = 1'b0;
    logic     reset;
    logic     key;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;

    logic [31:0] lfsr_state;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;
    int          rounds_expected;
    logic        expected_won[$];  // one entry per round still to be judged

    game_top game_top_inst (.*);

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout: no end of test after %0d cycles", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            error_count++;
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h8020_0003;
        return state >> 1;
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
        end
    endtask

    // torpedo flies straight up, so only a still target above it in its column is hit
    function automatic logic expected_win(input int tx, input int ty, input int tdx,
                                          input int tdy, input int px, input int py);
        logic in_column;
        in_column = (tx < px + sprite_size) && (px < tx + sprite_size);
        return (tdx == 0) && (tdy == 0) && in_column && (ty < py);
    endfunction

    function automatic logic [31:0] field_mask(input wb_addr_t addr);
        case (addr)
            reg_control:                         return 32'h0000_0001;
            reg_target_start, reg_torpedo_start: return 32'h03FF_03FF;
            reg_target_delta, reg_torpedo_delta: return 32'h000F_000F;
            reg_step_period:                     return 32'h0000_FFFF;
            reg_end_delay:                       return 32'h0000_00FF;
            default:                             return 32'h0000_0000;
        endcase
    endfunction

    function automatic wb_data_t config_pattern(input int addr);
        return 32'hA5C3_96F0 ^ (32'h1111_1111 * addr);
    endfunction

    function automatic wb_data_t pack_xy(input int x, input int y);
        return wb_data_t'(((y & 32'h3FF) << 16) | (x & 32'h3FF));
    endfunction

    function automatic wb_data_t pack_delta(input int dx, input int dy);
        return wb_data_t'(((dy & 32'hF) << 16) | (dx & 32'hF));  // two's complement nibbles
    endfunction

    task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
        @(negedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= addr;
        wb_dat_w <= data;
        do
        begin
            @(negedge clk);
        end
        while (!wb_ack);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
        @(negedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= addr;
        do
        begin
            @(negedge clk);
        end
        while (!wb_ack);
        data   = wb_dat_r;  // valid while ack is high
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic wait_status(input logic over, output wb_data_t status);
        do
        begin
            wb_read(reg_status, status);
        end
        while (status[1] !== over);
    endtask

    // judges each round on the first status read that shows game over
    always @(negedge clk)
    begin
        if (wb_ack && !wb_we && wb_adr == reg_status && wb_dat_r[1]
            && expected_won.size() > 0)
            check_value("game_won", {31'd0, wb_dat_r[0]}, {31'd0, expected_won.pop_front()});
    end

    task automatic play_round(input int tx, input int ty, input int tdx, input int tdy,
                              input logic shoot);
        wb_data_t status;
        wb_write(reg_target_start, pack_xy(tx, ty));
        wb_write(reg_target_delta, pack_delta(tdx, tdy));
        expected_won.push_back(expected_win(tx, ty, tdx, tdy, torpedo_x, torpedo_y));
        key <= shoot;
        wb_write(reg_control, 32'd1);
        wb_write(reg_control, 32'd0);  // a single round
        rounds_expected++;
        wait_status(1'b1, status);
        key <= 1'b0;
        wait_status(1'b0, status);
        check_value("rounds_played", {24'd0, status[15:8]}, rounds_expected);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
        end
    endtask

    initial
    begin
        wb_data_t data;
        int       errors_before;
        int       tx;
        int       offset;

        lfsr_state      = 32'h4764_4da5;
        error_count     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        cycle_count     = 0;
        rounds_expected = 0;
        reset    = 1'b1;
        key      = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (4) @(negedge clk);
        reset <= 1'b0;

        errors_before = error_count;
        wb_read(reg_status, data);
        check_value("status", data, 32'd0);
        wb_read(reg_control, data);
        check_value("control", data, 32'd0);
        for (int a = 1; a < 7; a++)
            wb_write(wb_addr_t'(a), config_pattern(a));
        for (int a = 1; a < 7; a++)
        begin
            wb_read(wb_addr_t'(a), data);
            check_value($sformatf("register %0d", a), data,
                        config_pattern(a) & field_mask(wb_addr_t'(a)));
        end
        wb_write(reg_status, 32'hFFFF_FFFF);  // read only
        wb_read(reg_status, data);
        check_value("status", data, 32'd0);
        finish_test("register access", errors_before);

        wb_write(reg_torpedo_start, pack_xy(torpedo_x, torpedo_y));
        wb_write(reg_torpedo_delta, pack_delta(0, -4));
        wb_write(reg_step_period, step_clocks);
        wb_write(reg_end_delay, end_steps);

        errors_before = error_count;
        play_round(620, 100, 2, 0, 1'b0);  // drifts off the right edge
        finish_test("lost round", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 4; i++)
        begin
            if (i < 3)
            begin
                draw_bits(4, offset);
                tx = torpedo_x - sprite_size + 1 + offset % 15;
            end
            else
            begin
                draw_bits(6, offset);
                tx = 400 + offset;  // well clear of the column
            end
            play_round(tx, target_y, 0, 0, 1'b1);
        end
        finish_test("hit rounds", errors_before);

        errors_before = error_count;
        wb_write(reg_target_start, pack_xy(620, 100));
        wb_write(reg_target_delta, pack_delta(2, 0));
        expected_won.push_back(expected_win(620, 100, 2, 0, torpedo_x, torpedo_y));
        wb_write(reg_control, 32'd1);  // left on, so the FSM starts again by itself
        wait_status(1'b1, data);
        wait_status(1'b0, data);
        expected_won.push_back(expected_win(620, 100, 2, 0, torpedo_x, torpedo_y));
        wait_status(1'b1, data);
        wb_write(reg_control, 32'd0);
        wait_status(1'b0, data);
        rounds_expected += 2;
        check_value("rounds_played", {24'd0, data[15:8]}, rounds_expected);
        finish_test("round restart", errors_before);

        errors_before = error_count;
        repeat (idle_cycles) @(negedge clk);
        wb_read(reg_status, data);
        check_value("rounds_played", {24'd0, data[15:8]}, rounds_expected);
        check_value("game_over", {31'd0, data[1]}, 32'd0);
        finish_test("run cleared", errors_before);

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
